// ==== hdl/myo_bridge_pkg.sv ====
// myo bridge package with frame geometry, register tables and Avalon bus types
package myo_bridge_pkg;

  localparam int frame_bytes_lp  = 86;
  localparam int status_bytes_lp = 48;
  localparam int wr_entries_lp   = 50;
  localparam int rd_entries_lp   = 20;

  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  rx_idx_t;
  typedef logic [5:0]  st_idx_t;
  // upper byte is the register group, lower byte the motor number
  typedef logic [15:0] av_addr_t;
  typedef logic [31:0] av_data_t;

  // how a write entry picks its value out of the frame
  typedef enum logic [2:0] {
    fk_half = 3'd0,
    fk_word = 3'd1,
    fk_flag = 3'd2,
    fk_pair = 3'd3,
    fk_byte = 3'd4
  } field_kind_e;

  typedef struct packed {
    av_addr_t    addr;
    rx_idx_t     offset;
    logic [2:0]  bit_pos;
    field_kind_e kind;
  } wr_entry_t;

  typedef struct packed {
    av_addr_t addr;
    st_idx_t  offset;
    logic     wide;
  } rd_entry_t;

  typedef struct packed {
    av_addr_t address;
    av_data_t writedata;
    logic     write;
    logic     read;
  } av_req_t;

  typedef wr_entry_t [wr_entries_lp-1:0] wr_table_t;
  typedef rd_entry_t [rd_entries_lp-1:0] rd_table_t;

  function automatic wr_entry_t wr_ent(int grp, int mot, int off, int bpos, field_kind_e k);
    wr_entry_t e;
    e.addr    = {8'(grp), 8'(mot)};
    e.offset  = rx_idx_t'(off);
    e.bit_pos = 3'(bpos);
    e.kind    = k;
    return e;
  endfunction

  function automatic wr_table_t build_wr_table();
    wr_table_t t;
    int        j;
    for (int i = 0; i < wr_entries_lp; i++) begin
      if (i < 12) begin
        // gains Kp, Ki, Kd
        t[i] = wr_ent(i / 4, i % 4, 2 * i, 0, fk_half);
      end else if (i < 16) begin
        // position setpoint
        j    = i - 12;
        t[i] = wr_ent(3, j, 24 + 4 * j, 0, fk_word);
      end else if (i < 36) begin
        // output and integral limits, deadband
        j    = i - 16;
        t[i] = wr_ent(5 + j / 4, j % 4, 40 + 2 * j, 0, fk_half);
      end else if (i == 36) begin
        t[i] = wr_ent(8'h0b, 3, 80, 7, fk_flag);
      end else if (i == 37) begin
        t[i] = wr_ent(8'h0c, 3, 80, 6, fk_flag);
      end else if (i < 42) begin
        // controller resets, bits 5 down to 2
        t[i] = wr_ent(8'h0d, 3, 80, 43 - i, fk_flag);
      end else if (i < 46) begin
        // control modes, high pair first
        t[i] = wr_ent(8'h0a, 3, 81, 2 * (45 - i), fk_pair);
      end else begin
        t[i] = wr_ent(8'h14, i - 46, 82 + i - 46, 0, fk_byte);
      end
    end
    return t;
  endfunction

  function automatic rd_table_t build_rd_table();
    rd_table_t t;
    int        j;
    int        grp;
    for (int i = 0; i < rd_entries_lp; i++) begin
      if (i < 4) begin
        // 32-bit positions first
        t[i] = '{addr: {8'h0b, 8'(i)}, offset: st_idx_t'(4 * i), wide: 1'b1};
      end else begin
        j = i - 4;
        case (j / 4)
          0:       grp = 8'h0c;
          1:       grp = 8'h0e;
          2:       grp = 8'h0d;
          default: grp = 8'h0f;
        endcase
        t[i] = '{addr: {8'(grp), 8'(j % 4)}, offset: st_idx_t'(16 + 2 * j), wide: 1'b0};
      end
    end
    return t;
  endfunction

  localparam wr_table_t wr_table_lp = build_wr_table();
  localparam rd_table_t rd_table_lp = build_rd_table();

endpackage

// ==== hdl/spi_byte_slave.sv ====
// spi byte slave, mode 0, assembling MOSI bytes and shifting status bytes out on MISO
module spi_byte_slave import myo_bridge_pkg::*; (
  input  logic  iCLK,
  input  logic  arst_n_i,
  input  logic  sck_i,
  input  logic  ss_n_i,
  input  logic  mosi_i,
  input  byte_t tx_byte_i,
  output logic  miso_o,
  output byte_t rx_byte_o,
  output logic  rx_valid_o,
  output logic  frame_active_o
);

  // two-flop synchronisers, bit 1 is the stable copy
  logic [1:0] sck_sync_q;
  logic [1:0] ss_sync_q;
  logic [1:0] mosi_sync_q;
  logic       sck_prev_q;
  logic       active_prev_q;
  logic       frame_active;
  logic       sck_rise;
  logic       sck_fall;
  logic       select_edge;
  logic       frame_start;
  logic [2:0] bit_cnt_q;
  logic       rx_valid_q;
  byte_t      rx_sr_q;
  byte_t      tx_sr_q;

  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_sync_q    <= '0;
      ss_sync_q     <= '1;
      mosi_sync_q   <= '0;
      sck_prev_q    <= 1'b0;
      active_prev_q <= 1'b0;
    end else begin
      sck_sync_q    <= {sck_sync_q[0], sck_i};
      ss_sync_q     <= {ss_sync_q[0], ss_n_i};
      mosi_sync_q   <= {mosi_sync_q[0], mosi_i};
      sck_prev_q    <= sck_sync_q[1];
      active_prev_q <= frame_active;
    end
  end

  assign frame_active = ~ss_sync_q[1];
  assign sck_rise     = sck_sync_q[1] & ~sck_prev_q;
  assign sck_fall     = ~sck_sync_q[1] & sck_prev_q;
  assign select_edge  = frame_active ^ active_prev_q;
  assign frame_start  = frame_active & ~active_prev_q;

  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q  <= '0;
      rx_valid_q <= 1'b0;
      tx_sr_q    <= '0;
    end else begin
      rx_valid_q <= 1'b0;
      if (select_edge) begin
        bit_cnt_q <= '0;
        // first byte must sit on MISO before the first rising SCK
        tx_sr_q   <= frame_start ? tx_byte_i : '0;
      end else if (frame_active) begin
        if (sck_rise) begin
          bit_cnt_q  <= bit_cnt_q + 3'd1;
          rx_valid_q <= (bit_cnt_q == 3'd7);
        end
        if (sck_fall) begin
          // counter wrapped, so a byte just finished
          if (bit_cnt_q == 3'd0) begin
            tx_sr_q <= tx_byte_i;
          end else begin
            tx_sr_q <= {tx_sr_q[6:0], 1'b0};
          end
        end
      end
    end
  end

  // msb first, sampled on rising SCK
  always_ff @(posedge iCLK) begin
    if (frame_active && sck_rise) begin
      rx_sr_q <= {rx_sr_q[6:0], mosi_sync_q[1]};
    end
  end

  assign miso_o         = tx_sr_q[7];
  assign rx_byte_o      = rx_sr_q;
  assign rx_valid_o     = rx_valid_q;
  assign frame_active_o = frame_active;

endmodule

// ==== hdl/frame_rx_buffer.sv ====
// frame receive buffer, stores host frame bytes in order and flags the end of each frame
module frame_rx_buffer import myo_bridge_pkg::*; (
  input  logic                       iCLK,
  input  logic                       arst_n_i,
  input  byte_t                      rx_byte_i,
  input  logic                       rx_valid_i,
  input  logic                       frame_active_i,
  output byte_t [frame_bytes_lp-1:0] frame_bytes_o,
  output logic                       frame_done_o
);

  rx_idx_t                    wr_idx_q;
  logic                       active_q;
  logic                       frame_done_q;
  logic                       idx_at_end;
  byte_t [frame_bytes_lp-1:0] frame_q;

  assign idx_at_end = (wr_idx_q == rx_idx_t'(frame_bytes_lp - 1));

  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_idx_q     <= '0;
      active_q     <= 1'b0;
      frame_done_q <= 1'b0;
    end else begin
      active_q     <= frame_active_i;
      // select released
      frame_done_q <= active_q & ~frame_active_i;
      if (frame_active_i && !active_q) begin
        wr_idx_q <= '0;
      end else if (rx_valid_i && !idx_at_end) begin
        wr_idx_q <= wr_idx_q + 7'd1;
      end
    end
  end

  // overlong frames keep overwriting the last byte
  always_ff @(posedge iCLK) begin
    if (rx_valid_i) begin
      frame_q[wr_idx_q] <= rx_byte_i;
    end
  end

  assign frame_bytes_o = frame_q;
  assign frame_done_o  = frame_done_q;

endmodule

// ==== hdl/status_tx_buffer.sv ====
// status transmit buffer, holds the read-back bytes and serves them to MISO one by one
module status_tx_buffer import myo_bridge_pkg::*; (
  input  logic     iCLK,
  input  logic     arst_n_i,
  input  logic     st_we_i,
  input  st_idx_t  st_offset_i,
  input  logic     st_wide_i,
  input  av_data_t st_data_i,
  input  logic     rx_valid_i,
  input  logic     frame_active_i,
  output byte_t    tx_byte_o
);

  byte_t [status_bytes_lp-1:0] st_mem_q;
  rx_idx_t                     rd_idx_q;
  logic                        active_q;
  logic                        idx_in_range;

  // little-endian, low half always, upper half only for wide reads
  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_mem_q <= '0;
    end else if (st_we_i) begin
      st_mem_q[st_offset_i]         <= st_data_i[7:0];
      st_mem_q[st_offset_i + 6'd1]  <= st_data_i[15:8];
      if (st_wide_i) begin
        st_mem_q[st_offset_i + 6'd2] <= st_data_i[23:16];
        st_mem_q[st_offset_i + 6'd3] <= st_data_i[31:24];
      end
    end
  end

  assign idx_in_range = (rd_idx_q < rx_idx_t'(status_bytes_lp));

  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_idx_q <= '0;
      active_q <= 1'b0;
    end else begin
      active_q <= frame_active_i;
      // rewind at frame end, ready for the next frame
      if (active_q && !frame_active_i) begin
        rd_idx_q <= '0;
      end else if (rx_valid_i && idx_in_range) begin
        rd_idx_q <= rd_idx_q + 7'd1;
      end
    end
  end

  // zero padding beyond the status bytes
  assign tx_byte_o = idx_in_range ? st_mem_q[rd_idx_q[5:0]] : '0;

endmodule

// ==== hdl/reg_sequencer.sv ====
// register sequencer, replays the frame as Avalon writes and then gathers status reads
module reg_sequencer import myo_bridge_pkg::*; (
  input  logic                       iCLK,
  input  logic                       arst_n_i,
  input  logic                       frame_done_i,
  input  byte_t [frame_bytes_lp-1:0] frame_bytes_i,
  input  av_data_t                   av_readdata_i,
  input  logic                       av_waitrequest_i,
  output av_req_t                    av_req_o,
  output logic                       st_we_o,
  output st_idx_t                    st_offset_o,
  output logic                       st_wide_o,
  output av_data_t                   st_data_o
);

  typedef enum logic [1:0] {
    idle_s,
    issue_s,
    wait_s,
    next_s
  } seq_state_e;

  seq_state_e state_q;
  logic [6:0] ent_q;
  logic [6:0] load_ent;
  logic       load_en;
  logic       load_is_wr;
  logic       xfer_done;
  logic       last_ent;
  logic [5:0] wr_sel;
  logic [4:0] rd_sel;
  logic [4:0] cur_rd_sel;
  logic       wr_q;
  logic       rd_q;
  av_addr_t   addr_q;
  av_data_t   wdata_q;
  logic       st_we_q;
  st_idx_t    st_offset_q;
  logic       st_wide_q;
  av_data_t   st_data_q;

  // value of one table entry taken from the frame, zero-extended
  function automatic av_data_t field_data(wr_entry_t e, byte_t [frame_bytes_lp-1:0] f);
    av_data_t d;
    d = '0;
    case (e.kind)
      fk_half: d[15:0] = {f[e.offset + 7'd1], f[e.offset]};
      fk_word: d = {f[e.offset + 7'd3], f[e.offset + 7'd2], f[e.offset + 7'd1], f[e.offset]};
      fk_flag: d[0]    = f[e.offset][e.bit_pos];
      fk_pair: d[1:0]  = f[e.offset][e.bit_pos +: 2];
      default: d[7:0]  = f[e.offset];
    endcase
    return d;
  endfunction

  // transfer completes in the first cycle with waitrequest low
  assign xfer_done  = ((state_q == issue_s) || (state_q == wait_s)) && !av_waitrequest_i;
  assign last_ent   = (ent_q == 7'(wr_entries_lp + rd_entries_lp - 1));
  assign load_en    = ((state_q == idle_s) && frame_done_i) || ((state_q == next_s) && !last_ent);
  assign load_ent   = (state_q == idle_s) ? 7'd0 : ent_q + 7'd1;
  assign load_is_wr = (load_ent < 7'(wr_entries_lp));
  assign wr_sel     = load_ent[5:0];
  assign rd_sel     = 5'(load_ent - 7'(wr_entries_lp));
  assign cur_rd_sel = 5'(ent_q - 7'(wr_entries_lp));

  always_ff @(posedge iCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= idle_s;
      ent_q   <= '0;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      st_we_q <= 1'b0;
    end else begin
      st_we_q <= xfer_done & rd_q;
      if (load_en) begin
        state_q <= issue_s;
        ent_q   <= load_ent;
        wr_q    <= load_is_wr;
        rd_q    <= !load_is_wr;
      end else if (xfer_done) begin
        // strobe drops here, next_s is the idle cycle
        state_q <= next_s;
        wr_q    <= 1'b0;
        rd_q    <= 1'b0;
      end else if (state_q == issue_s) begin
        state_q <= wait_s;
      end else if (state_q == next_s) begin
        // twentieth read finished
        state_q <= idle_s;
      end
    end
  end

  // request payload, held stable while the slave stalls
  always_ff @(posedge iCLK) begin
    if (load_en) begin
      if (load_is_wr) begin
        addr_q  <= wr_table_lp[wr_sel].addr;
        wdata_q <= field_data(wr_table_lp[wr_sel], frame_bytes_i);
      end else begin
        addr_q  <= rd_table_lp[rd_sel].addr;
        wdata_q <= '0;
      end
    end
    if (xfer_done && rd_q) begin
      st_offset_q <= rd_table_lp[cur_rd_sel].offset;
      st_wide_q   <= rd_table_lp[cur_rd_sel].wide;
      st_data_q   <= av_readdata_i;
    end
  end

  assign av_req_o = '{address: addr_q, writedata: wdata_q, write: wr_q, read: rd_q};

  assign st_we_o     = st_we_q;
  assign st_offset_o = st_offset_q;
  assign st_wide_o   = st_wide_q;
  assign st_data_o   = st_data_q;

endmodule

// ==== hdl/forearm_spi_bridge.sv ====
// forearm spi bridge, connects host SPI frames to motor-controller registers over Avalon
module forearm_spi_bridge import myo_bridge_pkg::*; (
  input  logic     iCLK,
  input  logic     arst_n_i,
  input  logic     sck_i,
  input  logic     ss_n_i,
  input  logic     mosi_i,
  input  av_data_t av_readdata_i,
  input  logic     av_waitrequest_i,
  output logic     miso_o,
  output av_req_t  av_req_o
);

  byte_t                      rx_byte;
  logic                       rx_valid;
  logic                       frame_active;
  byte_t                      tx_byte;
  byte_t [frame_bytes_lp-1:0] frame_bytes;
  logic                       frame_done;
  logic                       st_we;
  st_idx_t                    st_offset;
  logic                       st_wide;
  av_data_t                   st_data;

  spi_byte_slave spi_i (
    .iCLK           (iCLK),
    .arst_n_i       (arst_n_i),
    .sck_i          (sck_i),
    .ss_n_i         (ss_n_i),
    .mosi_i         (mosi_i),
    .tx_byte_i      (tx_byte),
    .miso_o         (miso_o),
    .rx_byte_o      (rx_byte),
    .rx_valid_o     (rx_valid),
    .frame_active_o (frame_active)
  );

  frame_rx_buffer rx_buf_i (
    .iCLK           (iCLK),
    .arst_n_i       (arst_n_i),
    .rx_byte_i      (rx_byte),
    .rx_valid_i     (rx_valid),
    .frame_active_i (frame_active),
    .frame_bytes_o  (frame_bytes),
    .frame_done_o   (frame_done)
  );

  // status bytes go out during the following frame
  status_tx_buffer st_buf_i (
    .iCLK           (iCLK),
    .arst_n_i       (arst_n_i),
    .st_we_i        (st_we),
    .st_offset_i    (st_offset),
    .st_wide_i      (st_wide),
    .st_data_i      (st_data),
    .rx_valid_i     (rx_valid),
    .frame_active_i (frame_active),
    .tx_byte_o      (tx_byte)
  );

  reg_sequencer seq_i (
    .iCLK             (iCLK),
    .arst_n_i         (arst_n_i),
    .frame_done_i     (frame_done),
    .frame_bytes_i    (frame_bytes),
    .av_readdata_i    (av_readdata_i),
    .av_waitrequest_i (av_waitrequest_i),
    .av_req_o         (av_req_o),
    .st_we_o          (st_we),
    .st_offset_o      (st_offset),
    .st_wide_o        (st_wide),
    .st_data_o        (st_data)
  );

endmodule

// ==== verif/myo_ctrl_model.sv ====
// motor controller model, an Avalon slave with a register file and random stalls
module myo_ctrl_model import myo_bridge_pkg::*; (
  input  logic     iCLK,
  input  av_req_t  av_req_i,
  input  logic     stall_i,
  output av_data_t av_readdata_o,
  output logic     av_waitrequest_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 64k registers, one per bus address
  av_data_t regs_q [65536];
  bit       written_q [65536];
  av_addr_t cur_addr;

  // unwritten registers read back a value built from every address bit
  function automatic av_data_t fill_pattern(av_addr_t a);
    return {a ^ 16'hc35a, ~a};
  endfunction

  assign cur_addr = av_req_i.address;

  // stall pattern comes from the LFSR in the testbench
  assign av_waitrequest_o = stall_i;

  assign av_readdata_o = written_q[cur_addr] ? regs_q[cur_addr] : fill_pattern(cur_addr);

  // a write lands in the cycle it completes
  always @(posedge iCLK) begin
    if (av_req_i.write && !stall_i) begin
      regs_q[cur_addr]    <= av_req_i.writedata;
      written_q[cur_addr] <= 1'b1;
    end
  end

endmodule

// ==== verif/tb_forearm_bridge.sv ====
// testbench for the forearm spi bridge that sends host frames and checks the Avalon traffic
module tb_forearm_bridge import myo_bridge_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int sck_half_lp  = 4;
  localparam int max_wait_lp  = 3;
  localparam int n_frames_lp  = 3;
  localparam int n_xfers_lp   = wr_entries_lp + rd_entries_lp;
  localparam int frame_cyc_lp = frame_bytes_lp * 8 * 2 * sck_half_lp + 64;
  localparam int seq_cyc_lp   = n_xfers_lp * (3 + max_wait_lp);
  // twice the nominal length of all frames and their sequences
  localparam int timeout_lp   = 2 * n_frames_lp * (frame_cyc_lp + seq_cyc_lp);

  logic        iCLK = 1'b0;
  logic        arst_n;
  logic        sck;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic        stall = 1'b0;
  av_data_t    av_readdata;
  logic        av_waitrequest;
  av_req_t     av_req;
  logic [31:0] data_lfsr  = 32'hd5bb;
  logic [31:0] stall_lfsr = 32'hd5bb;
  int          stall_run  = 0;
  int          xfers_left = 0;
  int          cycles     = 0;
  int          bus_errs   = 0;
  int          miso_errs  = 0;
  int          proto_errs = 0;
  byte_t       frame_q [frame_bytes_lp];
  byte_t       exp_status [frame_bytes_lp];
  byte_t       rd_grp_order [4] = '{8'h0c, 8'h0e, 8'h0d, 8'h0f};

  forearm_spi_bridge dut_i (
    .iCLK             (iCLK),
    .arst_n_i         (arst_n),
    .sck_i            (sck),
    .ss_n_i           (ss_n),
    .mosi_i           (mosi),
    .av_readdata_i    (av_readdata),
    .av_waitrequest_i (av_waitrequest),
    .miso_o           (miso),
    .av_req_o         (av_req)
  );

  myo_ctrl_model model_i (
    .iCLK             (iCLK),
    .av_req_i         (av_req),
    .stall_i          (stall),
    .av_readdata_o    (av_readdata),
    .av_waitrequest_o (av_waitrequest)
  );

  // galois form with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_byte(output byte_t b);
    for (int k = 0; k < 8; k++) begin
      data_lfsr = lfsr_step(data_lfsr);
      b = {b[6:0], data_lfsr[0]};
    end
  endtask

  // frame holds 12 gains, 4 setpoints, 20 limits, flags, modes and dividers
  function automatic void expect_write(int i, output av_addr_t a, output av_data_t d);
    int j;
    d = '0;
    if (i < 12) begin
      a       = {8'(i / 4), 8'(i % 4)};
      d[15:0] = {frame_q[2 * i + 1], frame_q[2 * i]};
    end else if (i < 16) begin
      j = i - 12;
      a = {8'h03, 8'(j)};
      d = {frame_q[27 + 4 * j], frame_q[26 + 4 * j], frame_q[25 + 4 * j], frame_q[24 + 4 * j]};
    end else if (i < 36) begin
      j       = i - 16;
      a       = {8'(5 + j / 4), 8'(j % 4)};
      d[15:0] = {frame_q[41 + 2 * j], frame_q[40 + 2 * j]};
    end else if (i < 42) begin
      // myo reset and spi activate before the controller resets, from bit 7 of byte 80 down
      a    = {(i == 36) ? 8'h0b : ((i == 37) ? 8'h0c : 8'h0d), 8'h03};
      d[0] = frame_q[80][43 - i];
    end else if (i < 46) begin
      a      = {8'h0a, 8'h03};
      d[1:0] = frame_q[81][2 * (45 - i) +: 2];
    end else begin
      a      = {8'h14, 8'(i - 46)};
      d[7:0] = frame_q[36 + i];
    end
  endfunction

  function automatic void expect_read(int i, output av_addr_t a, output int off, output int n);
    if (i < 4) begin
      a   = {8'h0b, 8'(i)};
      off = 4 * i;
      n   = 4;
    end else begin
      a   = {rd_grp_order[(i - 4) / 4], 8'((i - 4) % 4)};
      off = 16 + 2 * (i - 4);
      n   = 2;
    end
  endfunction

  // mode 0 with MISO sampled just before each rising SCK
  task automatic shift_byte(input byte_t tx, output byte_t rx);
    for (int b = 7; b >= 0; b--) begin
      mosi = tx[b];
      repeat (sck_half_lp) @(negedge iCLK);
      rx[b] = miso;
      sck   = 1'b1;
      repeat (sck_half_lp) @(negedge iCLK);
      sck = 1'b0;
    end
  endtask

  task automatic send_frame();
    byte_t rx;
    for (int i = 0; i < frame_bytes_lp; i++) begin
      draw_byte(frame_q[i]);
    end
    ss_n = 1'b0;
    repeat (8) @(negedge iCLK);
    for (int i = 0; i < frame_bytes_lp; i++) begin
      shift_byte(frame_q[i], rx);
      assert (rx == exp_status[i]) else begin
        miso_errs++;
        $display("** Error @ %0t: MISO byte %0d is %h, expected %h",
                 $time, i, rx, exp_status[i]);
      end
    end
    repeat (8) @(negedge iCLK);
    ss_n       = 1'b1;
    xfers_left = n_xfers_lp;
  endtask

  initial begin
    forever #5 iCLK = ~iCLK;
  end

  always @(negedge iCLK) begin
    stall_lfsr = lfsr_step(stall_lfsr);
    if (stall_lfsr[0] && stall_run < max_wait_lp) begin
      stall = 1'b1;
      stall_run++;
    end else begin
      stall     = 1'b0;
      stall_run = 0;
    end
  end

  // each completed transfer is compared with the table rule for its slot
  always @(posedge iCLK) begin
    av_addr_t a;
    av_data_t d;
    int       off;
    int       n;
    int       idx;
    if (arst_n && xfers_left != 0 && (av_req.write || av_req.read) && !av_waitrequest) begin
      idx = n_xfers_lp - xfers_left;
      if (idx < wr_entries_lp) begin
        expect_write(idx, a, d);
        assert (av_req.write && av_req.address == a && av_req.writedata == d) else begin
          bus_errs++;
          $display("** Error @ %0t: transfer %0d wr %b addr %h data %h, expected write %h %h",
                   $time, idx, av_req.write, av_req.address, av_req.writedata, a, d);
        end
      end else begin
        expect_read(idx - wr_entries_lp, a, off, n);
        assert (av_req.read && av_req.address == a) else begin
          bus_errs++;
          $display("** Error @ %0t: transfer %0d rd %b addr %h, expected read %h",
                   $time, idx, av_req.read, av_req.address, a);
        end
        for (int k = 0; k < n; k++) begin
          exp_status[off + k] = av_readdata[8 * k +: 8];
        end
      end
      xfers_left--;
    end
  end

  assert property (@(posedge iCLK) disable iff (!arst_n)
    (av_req.write || av_req.read) && av_waitrequest |=> $stable(av_req))
  else begin
    proto_errs++;
    $display("** Error @ %0t: request changed while waitrequest was high", $time);
  end

  assert property (@(posedge iCLK) disable iff (!arst_n)
    (av_req.write || av_req.read) |-> (xfers_left != 0))
  else begin
    proto_errs++;
    $display("** Error @ %0t: bus strobe with no transfer outstanding", $time);
  end

  assert property (@(posedge iCLK) disable iff (!arst_n) !(av_req.write && av_req.read))
  else begin
    proto_errs++;
    $display("** Error @ %0t: write and read strobes high together", $time);
  end

  always @(posedge iCLK) begin
    cycles++;
    if (cycles >= timeout_lp) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    arst_n = 1'b0;
    sck    = 1'b0;
    ss_n   = 1'b1;
    mosi   = 1'b0;
    for (int i = 0; i < frame_bytes_lp; i++) begin
      exp_status[i] = '0;
    end
    repeat (2) @(negedge iCLK);
    arst_n = 1'b1;
    // bus must stay quiet before the first frame
    repeat (20) @(negedge iCLK);
    for (int f = 0; f < n_frames_lp; f++) begin
      send_frame();
      while (xfers_left != 0) begin
        @(negedge iCLK);
      end
      repeat (10) @(negedge iCLK);
    end
    repeat (20) @(negedge iCLK);
    $display("errors: bus %0d, miso %0d, protocol %0d", bus_errs, miso_errs, proto_errs);
    if (bus_errs + miso_errs + proto_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/myo_bridge_pkg.sv
hdl/spi_byte_slave.sv
hdl/frame_rx_buffer.sv
hdl/status_tx_buffer.sv
hdl/reg_sequencer.sv
hdl/forearm_spi_bridge.sv
verif/myo_ctrl_model.sv
verif/tb_forearm_bridge.sv

// ==== Makefile ====
# Verilator flow for the forearm spi bridge
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_forearm_bridge
LINT_TOP  ?= forearm_spi_bridge
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(LINT_TOP)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
